/* rtl/sha_pkg.sv */
// SHA-256 package with the word and block types and the FIPS constants
package sha_pkg;

	typedef logic [31:0]  sha_word_t;   // One message or state word
	typedef logic [255:0] sha_state_t;  // Eight words with word 0 in the top bits
	typedef logic [511:0] sha_block_t;  // Sixteen words with word 0 in the top bits

	// Chaining source and output handling for one block
	typedef enum logic [1:0] {
		sha_midstate,  // Init hash in and result kept as midstate
		sha_final,     // Midstate in and result out
		sha_single     // Init hash in and result out
	} sha_mode_t;

	localparam int sha_rounds = 64;

	localparam sha_state_t sha_init_value = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	////////////////////////////////////////////////////////////////////////////
	// Round constants K0 to K63
	localparam sha_word_t sha_round_k [0:sha_rounds-1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage

/* rtl/miner_pkg.sv */
// Miner package with header nonce and counter types and the sequencer states
package miner_pkg;

	typedef logic [639:0] header_t;      // 80 byte header with byte 0 in the top bits
	typedef logic [31:0]  nonce_t;
	typedef logic [47:0]  hash_count_t;  // Total double hashes done

	// Run phases before the repeating second block period
	typedef enum logic [1:0] {
		seq_idle,
		seq_capture,      // Header and start nonce latched
		seq_first_block   // First block loaded then second block period
	} seq_state_t;

	// One core pass per block
	localparam int block_period = sha_pkg::sha_rounds;

endpackage

/* rtl/button_debounce.sv */
// Fire button debounce giving a short press strobe and a long press level
module button_debounce #(
	parameter int press_cycles   = 240000,    // 5 ms at 48 MHz
	parameter int pulse_cycles   = 960000,
	parameter int long_cycles    = 33554432,  // About 0.7 s
	parameter int release_cycles = 4800000
) (
	input  logic clk,
	input  logic reset,
	input  logic button,
	output logic press_pulse,
	output logic long_press
);

	localparam int held_max = (long_cycles > press_cycles + pulse_cycles) ?
		long_cycles : press_cycles + pulse_cycles;
	localparam int held_w   = $clog2(held_max + 1);
	localparam int rel_w    = $clog2(release_cycles + 1);

	typedef enum logic [2:0] {
		deb_idle,
		deb_wait_press,
		deb_pulse,
		deb_wait_long,
		deb_long,
		deb_wait_off,
		deb_wait_long_off
	} deb_state_t;

	logic [2:0]        sync;      // Metastability chain
	logic              btn;
	deb_state_t        state;
	logic [held_w-1:0] held;      // Time since first press seen
	logic [rel_w-1:0]  released;  // Time since release

	always_ff @(posedge clk) begin
		sync <= {sync[1:0], button};
	end
	assign btn = sync[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= deb_idle;
		end else begin
			case (state)
				deb_idle:
					if (btn) state <= deb_wait_press;
				deb_wait_press:
					if (!btn) state <= deb_idle;  // Glitch
					else if (held == held_w'(press_cycles)) state <= deb_pulse;
				deb_pulse:
					if (held == held_w'(press_cycles + pulse_cycles)) state <= deb_wait_long;
				deb_wait_long:
					if (!btn) state <= deb_wait_off;
					else if (held >= held_w'(long_cycles)) state <= deb_long;
				deb_long:
					if (!btn) state <= deb_wait_long_off;
				deb_wait_off:
					if (btn) state <= deb_wait_long;  // Bounce on release
					else if (released == rel_w'(release_cycles)) state <= deb_idle;
				deb_wait_long_off:
					if (btn) state <= deb_long;
					else if (released == rel_w'(release_cycles)) state <= deb_idle;
				default:
					state <= deb_idle;
			endcase
		end
	end

	// Counters and the press strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			held        <= '0;
			released    <= '0;
			press_pulse <= 1'b0;
		end else begin
			if (state == deb_idle) held <= '0;
			else if (held < held_w'(held_max)) held <= held + 1'b1;  // Saturate
			if (state == deb_wait_off || state == deb_wait_long_off) released <= released + 1'b1;
			else released <= '0;
			press_pulse <= (state == deb_wait_press) && btn && (held == held_w'(press_cycles));
		end
	end

	assign long_press = (state == deb_long) || (state == deb_wait_long_off);

endmodule

/* rtl/search_sequencer.sv */
// Search run control scheduling header capture and SHA block loads
module search_sequencer import miner_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic press_pulse,
	input  logic long_press,
	input  logic hit,
	output logic capture,
	output logic load_block,
	output logic block_sel,
	output logic next_nonce,
	output logic continuous
);

	localparam int step_w = $clog2(block_period);

	seq_state_t        state;
	logic [step_w-1:0] step;        // Position in the block period
	logic              long_q;
	logic              fresh;       // Second block of this run not loaded yet
	logic              go;
	logic              period_end;

	// Continuous search starts on the long press edge
	always_ff @(posedge clk) begin
		if (reset) begin
			long_q     <= 1'b0;
			continuous <= 1'b0;
		end else begin
			long_q <= long_press;
			if (long_press && !long_q) continuous <= 1'b1;
			else if (press_pulse || hit) continuous <= 1'b0;  // Stop on press or hit
		end
	end

	assign go = press_pulse || continuous;

	assign period_end = (state == seq_first_block) && (step == '0);
	assign load_block = period_end && (!block_sel || fresh || go);
	assign capture    = (state == seq_capture);
	assign next_nonce = load_block && block_sel;  // Advance after each second block

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= seq_idle;
			step      <= '0;
			block_sel <= 1'b0;
			fresh     <= 1'b0;
		end else begin
			case (state)
				seq_idle:
					if (go) state <= seq_capture;
				seq_capture: begin
					state     <= seq_first_block;
					step      <= '0;
					block_sel <= 1'b0;
					fresh     <= 1'b1;
				end
				seq_first_block: begin
					step <= (step == step_w'(block_period - 1)) ? '0 : step + 1'b1;
					if (period_end) begin
						if (!load_block) state <= seq_idle;  // Nothing more to load
						if (!block_sel) block_sel <= 1'b1;
						else if (load_block) fresh <= 1'b0;
					end
				end
				default:
					state <= seq_idle;
			endcase
		end
	end

endmodule

/* rtl/block_builder.sv */
// Block builder holding header and nonce and issuing padded blocks to the first core
module block_builder import sha_pkg::*, miner_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  header_t    header,
	input  logic       capture,
	input  logic       load_block,
	input  logic       block_sel,
	input  logic       next_nonce,
	output logic       in_valid,
	output sha_mode_t  mode,
	output sha_block_t message,
	output nonce_t     load_nonce
);

	header_t    hdr_q;
	nonce_t     nonce;         // Numeric value of the little endian nonce field
	sha_block_t first_block;
	sha_block_t second_block;

	function automatic nonce_t byte_swap(input nonce_t x);
		return {x[7:0], x[15:8], x[23:16], x[31:24]};
	endfunction

	// Header bytes 0 to 63
	assign first_block = hdr_q[639:128];

	// Bytes 64 to 75 then the nonce then padding and the 640 bit length
	assign second_block = {hdr_q[127:32], byte_swap(nonce), 32'h8000_0000,
		288'h0, 64'd640};

	always_ff @(posedge clk) begin
		if (capture) begin
			hdr_q <= header;
			nonce <= byte_swap(header[31:0]);  // Bytes 76 to 79 hold the start nonce
		end else if (next_nonce) begin
			nonce <= nonce + 1'b1;  // Full 32 bit count
		end
	end

	always_ff @(posedge clk) begin
		if (reset) in_valid <= 1'b0;
		else in_valid <= load_block;
	end

	// Block payload goes out with in_valid
	always_ff @(posedge clk) begin
		if (load_block) begin
			mode       <= block_sel ? sha_final : sha_midstate;
			message    <= block_sel ? second_block : first_block;
			load_nonce <= nonce;
		end
	end

endmodule

/* rtl/sha256_core.sv */
// SHA-256 compression core running one round per clock with a midstate store
module sha256_core import sha_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       in_valid,
	input  sha_mode_t  mode,
	input  sha_block_t message,
	output logic       out_valid,
	output sha_state_t hash
);

	localparam int round_w = $clog2(sha_rounds);

	logic               busy;
	logic [round_w-1:0] round;
	logic               done;         // Last round in progress
	sha_mode_t          mode_q;
	sha_state_t         work;         // Working variables a to h
	sha_state_t         work_next;
	sha_state_t         chain;        // Chaining value of the current block
	sha_state_t         midstate;
	sha_state_t         sum_state;
	sha_state_t         start_value;
	sha_word_t          w [0:15];     // Schedule window with W[t] in slot 0
	sha_word_t          w_new;
	sha_word_t          a;
	sha_word_t          b;
	sha_word_t          c;
	sha_word_t          d;
	sha_word_t          e;
	sha_word_t          f;
	sha_word_t          g;
	sha_word_t          h;
	sha_word_t          t1;
	sha_word_t          t2;

	function automatic sha_word_t rotr(input sha_word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	assign {a, b, c, d, e, f, g, h} = work;

	////////////////////////////////////////////////////////////////////////////
	// Round logic and message schedule

	always_comb begin
		t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g))
			+ sha_round_k[round] + w[0];
		t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
		work_next = {t1 + t2, a, b, c, d + t1, e, f, g};
		w_new = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9]
			+ (rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
	end

	// Chaining add on the last round
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			sum_state[255 - 32*i -: 32] = chain[255 - 32*i -: 32] + work_next[255 - 32*i -: 32];
		end
	end

	assign done      = busy && (round == round_w'(sha_rounds - 1));
	assign out_valid = done && (mode_q != sha_midstate);
	assign hash      = sum_state;

	// A final block may start on the cycle its midstate completes
	always_comb begin
		if (mode != sha_final) start_value = sha_init_value;
		else if (done && mode_q == sha_midstate) start_value = sum_state;  // Bypass
		else start_value = midstate;
	end

	////////////////////////////////////////////////////////////////////////////
	// Control and datapath registers

	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			round  <= '0;
			mode_q <= sha_single;
		end else if (in_valid) begin
			busy   <= 1'b1;
			round  <= '0;
			mode_q <= mode;
		end else if (busy) begin
			busy  <= !done;
			round <= round + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			work  <= start_value;
			chain <= start_value;
			for (int i = 0; i < 16; i++) begin
				w[i] <= message[511 - 32*i -: 32];  // Word 0 in the top bits
			end
		end else if (busy) begin
			work <= work_next;
			for (int i = 0; i < 15; i++) begin
				w[i] <= w[i+1];
			end
			w[15] <= w_new;
		end
	end

	always_ff @(posedge clk) begin
		if (done && mode_q == sha_midstate) midstate <= sum_state;
	end

	// No overlap of blocks inside the core
	accept_when_free: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> !busy || done);

	// Hash out a fixed number of rounds after the block went in
	out_latency: assert property (@(posedge clk) disable iff (reset)
		in_valid && mode != sha_midstate |-> ##sha_rounds out_valid);

	single_out: assert property (@(posedge clk) disable iff (reset)
		out_valid |=> !out_valid);

endmodule

/* rtl/nonce_result.sv */
// Second hash feed and result stage with nonce tracking and the hit test
module nonce_result import sha_pkg::*, miner_pkg::*; #(
	parameter int zero_bits = 32
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        first_valid,
	input  sha_state_t  first_hash,
	input  nonce_t      load_nonce,
	input  logic        load_block,      // Block strobe into the first core
	input  logic        second_valid,
	input  sha_state_t  second_hash,
	output logic        second_in_valid,
	output sha_block_t  second_message,
	output logic        result_valid,
	output sha_state_t  result_hash,
	output nonce_t      result_nonce,
	output logic        hit,
	output hash_count_t hash_count
);

	nonce_t nonce_first;   // Nonce of the block in the first core
	nonce_t nonce_second;  // Nonce of the block in the second core
	logic   halt;          // Hit seen so later first core results are dropped
	logic   zero_top;

	// 256 bit message padded to one block
	assign second_message  = {first_hash, 32'h8000_0000, 160'h0, 64'd256};
	assign second_in_valid = first_valid && !halt;

	assign zero_top = (second_hash[31 -: zero_bits] == '0);  // Top of the last word

	always_ff @(posedge clk) begin
		if (load_block) nonce_first <= load_nonce;
		if (first_valid) nonce_second <= nonce_first;
	end

	always_ff @(posedge clk) begin
		if (second_valid) begin
			result_hash  <= second_hash;
			result_nonce <= nonce_second;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			hit          <= 1'b0;
			hash_count   <= '0;
			halt         <= 1'b0;
		end else begin
			result_valid <= second_valid;
			hit          <= second_valid && zero_top;  // Pulses with result_valid
			if (second_valid) hash_count <= hash_count + 1'b1;
			if (load_block) halt <= 1'b0;  // New block ends the drain
			else if (hit) halt <= 1'b1;
		end
	end

endmodule

/* rtl/miner_top.sv */
// Double SHA-256 search engine top level joining button control and both cores
module miner_top import sha_pkg::*, miner_pkg::*; #(
	parameter int press_cycles   = 240000,
	parameter int pulse_cycles   = 960000,
	parameter int long_cycles    = 33554432,
	parameter int release_cycles = 4800000,
	parameter int zero_bits      = 32
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        fire_button,
	input  header_t     header,
	output logic        result_valid,
	output sha_state_t  result_hash,
	output nonce_t      result_nonce,
	output logic        hit,
	output hash_count_t hash_count,
	output logic        continuous
);

	logic       press_pulse;
	logic       long_press;
	logic       capture;
	logic       load_block;
	logic       block_sel;
	logic       next_nonce;
	logic       first_in_valid;
	sha_mode_t  first_mode;
	sha_block_t first_message;
	nonce_t     load_nonce;
	logic       first_out_valid;
	sha_state_t first_out_hash;
	logic       second_in_valid;
	sha_block_t second_message;
	logic       second_out_valid;
	sha_state_t second_out_hash;

	button_debounce #(
		.press_cycles  (press_cycles),
		.pulse_cycles  (pulse_cycles),
		.long_cycles   (long_cycles),
		.release_cycles(release_cycles)
	) debounce_inst (
		.clk        (clk),
		.reset      (reset),
		.button     (fire_button),
		.press_pulse(press_pulse),
		.long_press (long_press)
	);

	search_sequencer sequencer_inst (
		.clk(clk), .reset(reset),
		.press_pulse(press_pulse), .long_press(long_press), .hit(hit),
		.capture(capture), .load_block(load_block), .block_sel(block_sel),
		.next_nonce(next_nonce), .continuous(continuous)
	);

	block_builder builder_inst (
		.clk(clk), .reset(reset), .header(header),
		.capture(capture), .load_block(load_block), .block_sel(block_sel),
		.next_nonce(next_nonce), .in_valid(first_in_valid), .mode(first_mode),
		.message(first_message), .load_nonce(load_nonce)
	);

	sha256_core first_hash (
		.clk(clk), .reset(reset), .in_valid(first_in_valid), .mode(first_mode),
		.message(first_message), .out_valid(first_out_valid), .hash(first_out_hash)
	);

	// Second pass always starts from the initial hash
	sha256_core second_hash (
		.clk(clk), .reset(reset), .in_valid(second_in_valid), .mode(sha_single),
		.message(second_message), .out_valid(second_out_valid), .hash(second_out_hash)
	);

	nonce_result #(.zero_bits(zero_bits)) result_inst (
		.clk(clk), .reset(reset),
		.first_valid(first_out_valid), .first_hash(first_out_hash),
		.load_nonce(load_nonce), .load_block(first_in_valid),
		.second_valid(second_out_valid), .second_hash(second_out_hash),
		.second_in_valid(second_in_valid), .second_message(second_message),
		.result_valid(result_valid), .result_hash(result_hash),
		.result_nonce(result_nonce), .hit(hit), .hash_count(hash_count)
	);

endmodule

/* verification/sha256_model.svh */
// SHA-256 reference model giving the double hash of an 80 byte block header
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

function automatic sha_word_t ror32(input sha_word_t x, input int unsigned n);
	logic [63:0] twice;
	twice = {x, x} >> n;  // Rotate through a doubled word
	return twice[31:0];
endfunction

// One FIPS 180-4 compression of a 64 byte block onto a chaining value
function automatic sha_state_t compress_block(input sha_state_t chain_in, input sha_block_t blk);
	sha_word_t  sched [0:63];
	sha_word_t  v [0:7];  // Working variables a to h
	sha_word_t  s0;
	sha_word_t  s1;
	sha_word_t  ch;
	sha_word_t  maj;
	sha_word_t  temp1;
	sha_word_t  temp2;
	sha_state_t chain_out;
	for (int t = 0; t < 16; t++) begin
		sched[t] = blk[511 - 32*t -: 32];  // Big endian words
	end
	for (int t = 16; t < 64; t++) begin
		s0 = ror32(sched[t-15], 7) ^ ror32(sched[t-15], 18) ^ (sched[t-15] >> 3);
		s1 = ror32(sched[t-2], 17) ^ ror32(sched[t-2], 19) ^ (sched[t-2] >> 10);
		sched[t] = sched[t-16] + s0 + sched[t-7] + s1;
	end
	for (int i = 0; i < 8; i++) begin
		v[i] = chain_in[255 - 32*i -: 32];
	end
	for (int t = 0; t < 64; t++) begin
		s1    = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
		ch    = (v[4] & v[5]) ^ (~v[4] & v[6]);
		temp1 = v[7] + s1 + ch + sha_round_k[t] + sched[t];
		s0    = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
		maj   = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
		temp2 = s0 + maj;
		for (int i = 7; i > 0; i--) begin
			v[i] = v[i-1];
		end
		v[4] = v[4] + temp1;  // Old d plus temp1
		v[0] = temp1 + temp2;
	end
	for (int i = 0; i < 8; i++) begin
		chain_out[255 - 32*i -: 32] = chain_in[255 - 32*i -: 32] + v[i];
	end
	return chain_out;
endfunction

// Nonce field read as a little endian number
function automatic nonce_t header_nonce(input header_t hdr);
	return {hdr[7:0], hdr[15:8], hdr[23:16], hdr[31:24]};
endfunction

// SHA-256 of SHA-256 of the header with the nonce field replaced
function automatic sha_state_t double_hash(input header_t hdr, input nonce_t nonce);
	sha_block_t tail;
	sha_block_t outer;
	sha_state_t mid;
	sha_state_t inner;
	// Bytes 64 to 79, pad byte, zeros, 640 bit length
	tail = {hdr[127:32], nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24],
		8'h80, 312'h0, 64'd640};
	mid   = compress_block(sha_init_value, hdr[639:128]);
	inner = compress_block(mid, tail);
	outer = {inner, 8'h80, 184'h0, 64'd256};  // 32 byte digest as one block
	return compress_block(sha_init_value, outer);
endfunction

`endif

/* verification/tb_miner.sv */
// Testbench for the double SHA-256 miner with button stimulus and model checks
module tb_miner import sha_pkg::*, miner_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	`include "sha256_model.svh"

	localparam int clk_period      = 20;
	localparam int press_cycles    = 4;
	localparam int pulse_cycles    = 20;
	localparam int long_cycles     = 300;
	localparam int release_cycles  = 40;
	localparam int zero_bits       = 4;
	localparam int max_run_results = 256;  // Hash limit while waiting for a hit

	// Test lengths in block periods
	localparam int idle_periods    = 6;
	localparam int short_periods   = 12;
	localparam int long_periods    = 16 + max_run_results;
	localparam int stop_periods    = 32;
	localparam int watchdog_cycles =
		(idle_periods + short_periods + long_periods + stop_periods) * block_period + 2000;

	logic        clk;
	logic        reset;
	logic        fire_button;
	header_t     header;
	logic        result_valid;
	sha_state_t  result_hash;
	nonce_t      result_nonce;
	logic        hit;
	hash_count_t hash_count;
	logic        continuous;

	integer  seed = 99220;
	int      errors = 0;
	int      checks = 0;
	int      results_seen = 0;  // All results since reset
	int      first_hit = -1;    // Index of the first hit in the queues
	longint  cycle = 0;
	string   test_name = "reset";
	nonce_t  seen_nonce [$];    // Results of the current test
	longint  seen_cycle [$];

	miner_top #(
		.press_cycles  (press_cycles),
		.pulse_cycles  (pulse_cycles),
		.long_cycles   (long_cycles),
		.release_cycles(release_cycles),
		.zero_bits     (zero_bits)
	) miner_top_inst (
		.clk(clk), .reset(reset), .fire_button(fire_button), .header(header),
		.result_valid(result_valid), .result_hash(result_hash),
		.result_nonce(result_nonce), .hit(hit), .hash_count(hash_count),
		.continuous(continuous)
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// Hit when the top bits of the last hash word are all zero
	function automatic logic meets_target(input sha_state_t h);
		return h[31 -: zero_bits] == '0;
	endfunction

	task automatic report_failure(input string msg);
		errors++;
		$display("failure in %s, %s", test_name, msg);
	endtask

	task automatic compare_value(input string what, input logic [255:0] expected,
		input logic [255:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("error %s %s expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic require(input logic cond, input string msg);
		checks++;
		assert (cond) else report_failure(msg);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic press_button(input int hold);
		fire_button = 1'b1;
		idle_cycles(hold);
		fire_button = 1'b0;
	endtask

	task automatic random_header();
		for (int i = 0; i < 20; i++) begin
			header = {header[607:0], $random(seed)};  // 20 random words
		end
	endtask

	// New random header with no hit among its first nonces
	task automatic pick_hitless_header(input int count);
		logic quiet;
		quiet = 1'b0;
		while (!quiet) begin
			random_header();
			quiet = 1'b1;
			for (int i = 0; i < count; i++) begin
				if (meets_target(double_hash(header, nonce_t'(header_nonce(header) + i))))
					quiet = 1'b0;
			end
		end
	endtask

	task automatic clear_results();
		seen_nonce.delete();
		seen_cycle.delete();
		first_hit = -1;
	endtask

	task automatic await_results(input int count, input int limit, output logic ok);
		int waited;
		waited = 0;
		while (seen_nonce.size() < count && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		ok = (seen_nonce.size() >= count);
	endtask

	task automatic await_hit(input int limit, output logic ok);
		int waited;
		waited = 0;
		while (first_hit < 0 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		ok = (first_hit >= 0);
	endtask

	task automatic poll_continuous(input logic level, input int limit, output logic ok);
		int waited;
		waited = 0;
		while (continuous !== level && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		ok = (continuous === level);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result checker against the reference model

	always @(posedge clk) begin : compare
		sha_state_t exp_hash;
		if (!reset && result_valid) begin
			results_seen++;
			exp_hash = double_hash(header, result_nonce);
			compare_value("hash", exp_hash, result_hash);
			compare_value("hit flag", meets_target(exp_hash), hit);
			compare_value("hash count", results_seen, hash_count);
			if (hit && first_hit < 0) first_hit = seen_nonce.size();
			seen_nonce.push_back(result_nonce);
			seen_cycle.push_back(cycle);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : stimulus
		logic ok;
		int   count;
		clk         = 1'b0;
		reset       = 1'b1;
		fire_button = 1'b0;
		header      = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Reset state and a glitch below the press time
		test_name = "reset_idle";
		idle_cycles(20);
		press_button(press_cycles - 2);
		idle_cycles(300);
		compare_value("result count", 0, results_seen);
		compare_value("hash count", 0, hash_count);
		require(continuous === 1'b0, "continuous search set without a press");

		// One press, one nonce
		test_name = "short_press";
		random_header();
		clear_results();
		press_button(60);
		await_results(1, 400, ok);
		require(ok, "no result after a short press");
		idle_cycles(200);
		compare_value("result count", 1, seen_nonce.size());
		if (seen_nonce.size() > 0) compare_value("nonce", header_nonce(header), seen_nonce[0]);

		// Continuous search until the first hit
		test_name = "long_press";
		random_header();
		clear_results();
		fire_button = 1'b1;
		poll_continuous(1'b1, long_cycles + 100, ok);
		require(ok, "continuous search did not start on a long press");
		clear_results();  // Drops the single run of the press strobe
		fire_button = 1'b0;
		await_hit(max_run_results * block_period + 300, ok);
		require(ok, "no hit within the run limit");
		idle_cycles(3 * block_period + 20);
		require(continuous === 1'b0, "continuous search still set after a hit");
		if (first_hit >= 0) begin
			require(seen_nonce.size() - first_hit - 1 <= 1, "more than one result after the hit");
		end
		require(seen_nonce.size() > 0, "no results in continuous search");
		if (seen_nonce.size() > 0) compare_value("first nonce", header_nonce(header), seen_nonce[0]);
		for (int i = 1; i < seen_nonce.size(); i++) begin
			compare_value("nonce step", nonce_t'(seen_nonce[i-1] + 1), seen_nonce[i]);
			compare_value("result spacing", block_period, seen_cycle[i] - seen_cycle[i-1]);
		end

		// Short press ends a continuous run
		test_name = "short_stop";
		pick_hitless_header(4);
		clear_results();
		fire_button = 1'b1;
		poll_continuous(1'b1, long_cycles + 100, ok);
		require(ok, "continuous search did not start on a long press");
		clear_results();
		fire_button = 1'b0;
		await_results(3, 4 * block_period + 300, ok);
		require(ok, "continuous search gave too few results");
		require(continuous === 1'b1, "continuous search ended before the stop press");
		press_button(60);
		poll_continuous(1'b0, 100, ok);
		require(ok, "continuous search not stopped by a short press");
		idle_cycles(400);
		count = results_seen;
		idle_cycles(200);
		require(results_seen == count, "results still arriving after the stop press");

		// Counter agrees with every observed result
		test_name = "hash_count";
		compare_value("hash count", results_seen, hash_count);
		require(results_seen > 0, "no results seen in the whole run");

		$display("checks %0d errors %0d results %0d", checks, errors, results_seen);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Run length bound
	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the test sequence did not finish", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

/* build.f */
+incdir+verification
rtl/sha_pkg.sv
rtl/miner_pkg.sv
rtl/button_debounce.sv
rtl/search_sequencer.sv
rtl/block_builder.sv
rtl/sha256_core.sv
rtl/nonce_result.sv
rtl/miner_top.sv
verification/tb_miner.sv

/* Bender.yml */
package:
  name: miner

sources:
  - rtl/sha_pkg.sv
  - rtl/miner_pkg.sv
  - rtl/button_debounce.sv
  - rtl/search_sequencer.sv
  - rtl/block_builder.sv
  - rtl/sha256_core.sv
  - rtl/nonce_result.sv
  - rtl/miner_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_miner.sv
